// File: include/prefix_alu_params.svh
// Width and latency macros for the prefix ALU, included by the RTL and the testbench
`ifndef PREFIX_ALU_PARAMS_SVH
`define PREFIX_ALU_PARAMS_SVH

// Operand and result width
`define ALU_WIDTH 16

// Cycles from the input strobe to out_valid
`define ALU_LATENCY 2

`endif

// File: hw/alu_op_pkg.sv
// Opcode type shared by the configuration block, the add unit and the testbench
package alu_op_pkg;

	// Add/subtract opcodes
	// OP_SBB computes a - b - !carry_in, so carry out means no borrow
	typedef enum logic [1:0] {
		OP_ADD = 2'b00,
		OP_SUB = 2'b01,
		OP_ADC = 2'b10,
		OP_SBB = 2'b11
	} alu_op_e;

endpackage

// File: hw/alu_status_pkg.sv
// Bit positions of the status flags word, used by the add unit and the testbench
package alu_status_pkg;

	// Index of each flag inside the 4-bit flags output
	typedef enum logic [1:0] {
		FLAG_C = 2'd0,
		FLAG_Z = 2'd1,
		FLAG_N = 2'd2,
		FLAG_V = 2'd3
	} flag_idx_e;

endpackage

// File: hw/lf_prefix_tree.sv
// Ladner-Fischer carry network, instantiated by the prefix adder to turn bit P/G into carries
`timescale 1ns/1ps
`include "prefix_alu_params.svh"

module lf_prefix_tree (
	input  logic [`ALU_WIDTH-1:0] p,
	input  logic [`ALU_WIDTH-1:0] g,
	output logic [`ALU_WIDTH:1]   c
);

	localparam int W = `ALU_WIDTH;
	localparam int LVLS = $clog2(W);

	// Group generate/propagate per level, level 0 holds the bit pairs
	logic [LVLS:0][W-1:0] gg;
	logic [LVLS:0][W-1:0] pp;

	assign gg[0] = g;
	assign pp[0] = p;

	genvar l, i;
	generate
		// Sklansky-style combine over the odd positions only
		for (l = 1; l <= LVLS; l = l + 1) begin : g_lvl
			for (i = 0; i < W; i = i + 1) begin : g_bit
				if ((i % 2 == 1) && (((i >> (l - 1)) % 2) == 1)) begin : g_cell
					// Partner is the top of the next lower block
					localparam int J = ((i >> (l - 1)) << (l - 1)) - 1;
					assign gg[l][i] = gg[l-1][i] | (pp[l-1][i] & gg[l-1][J]);
					if (i < (1 << l)) begin : g_grey
						// Group spans down to bit 0, propagate no longer needed
						assign pp[l][i] = pp[l-1][i];
					end else begin : g_black
						assign pp[l][i] = pp[l-1][i] & pp[l-1][J];
					end
				end else begin : g_pass
					assign gg[l][i] = gg[l-1][i];
					assign pp[l][i] = pp[l-1][i];
				end
			end
		end

		// Carry k is the group generate of bits k-1 down to 0
		for (i = 0; i < W; i = i + 1) begin : g_carry
			if (i == 0) begin : g_lsb
				assign c[1] = gg[LVLS][0];
			end else if (i % 2 == 1) begin : g_odd
				assign c[i+1] = gg[LVLS][i];
			end else begin : g_even
				// Final grey row fills in the even positions
				assign c[i+1] = gg[LVLS][i] | (pp[LVLS][i] & gg[LVLS][i-1]);
			end
		end
	endgenerate

endmodule

// File: hw/prefix_adder.sv
// Combinational parallel-prefix adder, used by the add unit for its second stage
`timescale 1ns/1ps
`include "prefix_alu_params.svh"

module prefix_adder (
	input  logic [`ALU_WIDTH-1:0] a,
	input  logic [`ALU_WIDTH-1:0] b,
	input  logic                  cin,
	output logic [`ALU_WIDTH-1:0] sum,
	output logic                  cout
);

	localparam int W = `ALU_WIDTH;

	// Bit P/G shifted up by one so cin becomes the generate of position 0
	logic [W:0]   p_ext;
	logic [W:0]   g_ext;
	logic [W:1]   c;

	assign p_ext = {a ^ b, 1'b0};
	assign g_ext = {a & b, cin};

	lf_prefix_tree tree_i (
		.p (p_ext[W-1:0]),
		.g (g_ext[W-1:0]),
		.c (c)
	);

	// c[k+1] is the carry into operand bit k
	assign sum  = p_ext[W:1] ^ c;
	assign cout = g_ext[W] | (p_ext[W] & c[W]);

endmodule

// File: hw/alu_cfg_regs.sv
// Holds the current opcode and saturation enable, written by a one-cycle strobe
`timescale 1ns/1ps

module alu_cfg_regs
	import alu_op_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    cfg_we,
	input  alu_op_e cfg_op,
	input  logic    cfg_sat,
	output alu_op_e op,
	output logic    sat_en
);

	// New setting is visible from the cycle after the write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op     <= OP_ADD;
			sat_en <= 1'b0;
		end else if (cfg_we) begin
			op     <= cfg_op;
			sat_en <= cfg_sat;
		end
	end

endmodule

// File: hw/add_unit.sv
// Two-stage add/subtract pipeline with saturation and status flags, driven by the top level
`timescale 1ns/1ps
`include "prefix_alu_params.svh"

module add_unit
	import alu_op_pkg::*;
	import alu_status_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic [`ALU_WIDTH-1:0] a,
	input  logic [`ALU_WIDTH-1:0] b,
	input  logic                  carry_in,
	input  alu_op_e               op,
	input  logic                  sat_en,
	output logic                  out_valid,
	output logic [`ALU_WIDTH-1:0] result,
	output logic [3:0]            flags
);

	localparam int W = `ALU_WIDTH;

	logic         sub_op;
	logic         cin_d;
	logic         s1_valid;
	logic [W-1:0] s1_a;
	logic [W-1:0] s1_b;
	logic         s1_cin;
	logic         s1_sat;
	logic [W-1:0] sum;
	logic         cout;
	logic         ovf;
	logic [W-1:0] res_d;
	logic [3:0]   flags_d;

	// Operand conditioning
	always_comb begin
		sub_op = (op == OP_SUB) || (op == OP_SBB);
		case (op)
			OP_ADD: cin_d = 1'b0;
			OP_SUB: cin_d = 1'b1;
			OP_ADC: cin_d = carry_in;
			OP_SBB: cin_d = carry_in;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	// Stage 1 payload, loaded only on a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_a   <= a;
			s1_b   <= sub_op ? ~b : b;
			s1_cin <= cin_d;
			s1_sat <= sat_en;
		end
	end

	prefix_adder adder_i (
		.a    (s1_a),
		.b    (s1_b),
		.cin  (s1_cin),
		.sum  (sum),
		.cout (cout)
	);

	// Signed overflow against the effective b operand
	always_comb begin
		ovf = (s1_a[W-1] == s1_b[W-1]) && (sum[W-1] != s1_a[W-1]);
		if (s1_sat && ovf) begin
			// Clamp toward the sign of a
			res_d = {s1_a[W-1], {(W-1){~s1_a[W-1]}}};
		end else begin
			res_d = sum;
		end
		flags_d         = '0;
		flags_d[FLAG_C] = cout;
		flags_d[FLAG_Z] = (res_d == '0);
		flags_d[FLAG_N] = res_d[W-1];
		flags_d[FLAG_V] = ovf;
	end

	// Stage 2 output registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			result    <= '0;
			flags     <= '0;
		end else begin
			out_valid <= s1_valid;
			if (s1_valid) begin
				result <= res_d;
				flags  <= flags_d;
			end
		end
	end

endmodule

// File: hw/prefix_alu_top.sv
// Top level of the prefix ALU, joins the configuration register and the add pipeline
`timescale 1ns/1ps
`include "prefix_alu_params.svh"

module prefix_alu_top
	import alu_op_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cfg_we,
	input  alu_op_e               cfg_op,
	input  logic                  cfg_sat,
	input  logic                  in_valid,
	input  logic [`ALU_WIDTH-1:0] a,
	input  logic [`ALU_WIDTH-1:0] b,
	input  logic                  carry_in,
	output logic                  out_valid,
	output logic [`ALU_WIDTH-1:0] result,
	output logic [3:0]            flags
);

	// Current operation setting
	alu_op_e op;
	logic    sat_en;

	alu_cfg_regs cfg_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.cfg_we  (cfg_we),
		.cfg_op  (cfg_op),
		.cfg_sat (cfg_sat),
		.op      (op),
		.sat_en  (sat_en)
	);

	// Results appear ALU_LATENCY edges after the input strobe
	add_unit add_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.carry_in  (carry_in),
		.op        (op),
		.sat_en    (sat_en),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

endmodule

// File: verification/prefix_alu_tb.sv
// Trace-driven testbench for the prefix ALU, reads verification/alu_trace.txt from the project root
`timescale 1ns/1ps
`include "prefix_alu_params.svh"

module prefix_alu_tb
	import alu_op_pkg::*;
();

	localparam int W = `ALU_WIDTH;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 20;

	logic         clk;
	logic         rst_n;
	logic         cfg_we;
	alu_op_e      cfg_op;
	logic         cfg_sat;
	logic         in_valid;
	logic [W-1:0] a;
	logic [W-1:0] b;
	logic         carry_in;
	logic         out_valid;
	logic [W-1:0] result;
	logic [3:0]   flags;

	// Trace contents, one entry per non-comment line
	logic [7:0]   tr_kind[$];
	logic [W-1:0] tr_a[$];
	logic [W-1:0] tr_b[$];
	logic         tr_cin[$];
	logic [W-1:0] tr_res[$];
	logic [3:0]   tr_flags[$];
	logic [1:0]   tr_op[$];
	logic         tr_sat[$];

	// Outstanding transactions
	logic [W-1:0] exp_res[$];
	logic [3:0]   exp_flags[$];
	int           strobe_cycle[$];

	int   cycle = 0;
	logic trace_loaded = 1'b0;

	prefix_alu_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_we    (cfg_we),
		.cfg_op    (cfg_op),
		.cfg_sat   (cfg_sat),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.carry_in  (carry_in),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic report_failure();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic load_trace();
		int           fd;
		int           n;
		string        line;
		logic [7:0]   kind;
		logic [W-1:0] va;
		logic [W-1:0] vb;
		logic [W-1:0] vr;
		logic [3:0]   vf;
		logic         vc;
		logic [1:0]   vop;
		logic         vsat;
		fd = $fopen("verification/alu_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open trace file verification/alu_trace.txt");
			report_failure();
		end else begin
			while ($fgets(line, fd) > 0) begin
				kind = 8'h00;
				n = $sscanf(line, "%c", kind);
				if (kind == "O") begin
					n = $sscanf(line, "%c %h %h %h %h %h", kind, va, vb, vc, vr, vf);
					assert (n == 6) else begin
						$display("malformed operation line in trace: %s", line);
						report_failure();
					end
					tr_kind.push_back(kind);
					tr_a.push_back(va);
					tr_b.push_back(vb);
					tr_cin.push_back(vc);
					tr_res.push_back(vr);
					tr_flags.push_back(vf);
					tr_op.push_back(2'b00);
					tr_sat.push_back(1'b0);
				end else if (kind == "C" || kind == "S") begin
					n = $sscanf(line, "%c %h %h", kind, vop, vsat);
					assert (n == 3) else begin
						$display("malformed configuration line in trace: %s", line);
						report_failure();
					end
					tr_kind.push_back(kind);
					tr_a.push_back('0);
					tr_b.push_back('0);
					tr_cin.push_back(1'b0);
					tr_res.push_back('0);
					tr_flags.push_back(4'h0);
					tr_op.push_back(vop);
					tr_sat.push_back(vsat);
				end
			end
			$fclose(fd);
		end
	endtask

	// Stimulus, everything changes on the falling edge
	initial begin : drive
		int          idx;
		int          gap;
		clk      = 1'b0;
		rst_n    = 1'b0;
		cfg_we   = 1'b0;
		cfg_op   = OP_ADD;
		cfg_sat  = 1'b0;
		in_valid = 1'b0;
		a        = '0;
		b        = '0;
		carry_in = 1'b0;
		void'($urandom(32'h1280));
		load_trace();
		trace_loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		for (idx = 0; idx < tr_kind.size(); idx++) begin
			if (tr_kind[idx] == "C") begin
				cfg_we  = 1'b1;
				cfg_op  = alu_op_e'(tr_op[idx]);
				cfg_sat = tr_sat[idx];
				@(negedge clk);
				// No gap, so the next strobe lands one cycle after the write
				cfg_we = 1'b0;
			end else if (tr_kind[idx] == "S") begin
				// Held into the next operation's cycle
				cfg_we  = 1'b1;
				cfg_op  = alu_op_e'(tr_op[idx]);
				cfg_sat = tr_sat[idx];
			end else begin
				in_valid = 1'b1;
				a        = tr_a[idx];
				b        = tr_b[idx];
				carry_in = tr_cin[idx];
				exp_res.push_back(tr_res[idx]);
				exp_flags.push_back(tr_flags[idx]);
				strobe_cycle.push_back(cycle);
				@(negedge clk);
				in_valid = 1'b0;
				cfg_we   = 1'b0;
				gap = $urandom_range(2, 0);
				repeat (gap) @(negedge clk);
			end
		end
		repeat (`ALU_LATENCY + 2) @(negedge clk);
		if (exp_res.size() == 0 && strobe_cycle.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("%0d results never arrived", exp_res.size());
			report_failure();
		end
	end

	always @(negedge clk) begin : result_check
		logic [W-1:0] er;
		logic [3:0]   ef;
		if (rst_n && out_valid) begin
			if (exp_res.size() == 0) begin
				$display("out_valid asserted with no transaction outstanding");
				report_failure();
			end else begin
				er = exp_res.pop_front();
				ef = exp_flags.pop_front();
				assert (result == er) else begin
					$display("error result expected 0x%h actual 0x%h", er, result);
					report_failure();
				end
				assert (flags == ef) else begin
					$display("error flags expected 0x%h actual 0x%h", ef, flags);
					report_failure();
				end
			end
		end
	end

	// Each result must come exactly ALU_LATENCY edges after its strobe
	always @(negedge clk) begin : latency_check
		int sc;
		if (rst_n && out_valid) begin
			if (strobe_cycle.size() > 0) begin
				sc = strobe_cycle.pop_front();
				assert (cycle - sc == `ALU_LATENCY) else begin
					$display("result came %0d cycles after its strobe instead of %0d",
						cycle - sc, `ALU_LATENCY);
					report_failure();
				end
			end
		end else if (strobe_cycle.size() > 0 && cycle - strobe_cycle[0] > `ALU_LATENCY) begin
			$display("no result within %0d cycles of a strobe", `ALU_LATENCY);
			report_failure();
		end
	end

	initial begin : watchdog
		wait (trace_loaded);
		repeat (RESET_CYCLES + tr_kind.size() * 4 + DRAIN_CYCLES) @(posedge clk);
		$display("timeout, the trace did not complete in the expected time");
		report_failure();
	end

endmodule

// File: prefix_alu_top.f
+incdir+include
hw/alu_op_pkg.sv
hw/alu_status_pkg.sv
hw/lf_prefix_tree.sv
hw/prefix_adder.sv
hw/alu_cfg_regs.sv
hw/add_unit.sv
hw/prefix_alu_top.sv
verification/prefix_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the prefix ALU testbench with Verilator, run it, and judge the log

TOP=prefix_alu_tb
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f prefix_alu_top.f --top-module "$TOP" -Mdir "$OBJ" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

if [ ! -x "./$OBJ/$TOP" ]; then
	echo "Simulation binary ./$OBJ/$TOP not found"
	exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" "$LOG"; then
	echo "Simulation PASSED"
	exit 0
else
	echo "Simulation FAILED"
	exit 1
fi

// File: verification/alu_trace.txt
# O a b carry_in expected_result expected_flags (hex, flags bit3..0 = V N Z C)
# C op sat writes config alone, S op sat writes in the same cycle as the next O (op 0 ADD 1 SUB 2 ADC 3 SBB)
O 0001 0002 0 0003 0
O FFFF 0001 0 0000 3
O FFFF 0001 1 0000 3
O 7FFF 0001 0 8000 C
O 8000 8000 0 0000 B
O 1234 4321 0 5555 0
O 0000 0000 0 0000 2
C 1 0
O 0005 0003 0 0002 1
O 0003 0005 1 FFFE 4
O 1234 1234 0 0000 3
O 8000 0001 0 7FFF 9
O 7FFF FFFF 0 8000 C
C 2 0
O 0001 0002 1 0004 0
O 0001 0002 0 0003 0
O FFFF 0000 1 0000 3
O 7FFF 0000 1 8000 C
C 3 0
O 0005 0003 1 0002 1
O 0005 0003 0 0001 1
O 0000 0000 0 FFFF 4
O 0000 0000 1 0000 3
C 0 1
O 7FFF 0001 0 7FFF 8
O 8000 FFFF 0 8000 D
O 0100 0200 0 0300 0
C 1 1
O 8000 0001 0 8000 D
O 7FFF FFFF 0 7FFF 8
O 0010 0001 0 000F 1
S 0 0
O 0005 0003 0 0002 1
O 0005 0003 0 0008 0
C 1 0
O 0009 0009 0 0000 3
C 0 0
O 0101 0202 0 0303 0
O FFFE 0001 0 FFFF 4
O 8001 7FFF 0 0000 3
